/* sim.f */
hw/sort_geom_pkg.sv
hw/sort_ctrl_pkg.sv
hw/sort_job_regs.sv
hw/chunk_framer.sv
hw/chunk_sorter.sv
hw/merge_unit.sv
hw/merge_sort_top.sv
verif/merge_sort_props.sv
verif/tb_merge_sort.sv

/* Bender.yml */
package:
  name: merge_sort

sources:
  - files:
      - hw/sort_geom_pkg.sv
      - hw/sort_ctrl_pkg.sv
      - hw/sort_job_regs.sv
      - hw/chunk_framer.sv
      - hw/chunk_sorter.sv
      - hw/merge_unit.sv
      - hw/merge_sort_top.sv

  - target: test
    files:
      - verif/merge_sort_props.sv
      - verif/tb_merge_sort.sv

/* verif/tb_merge_sort.sv */
`timescale 1ns/1ns

module tb_merge_sort import sort_geom_pkg::*; ();

    localparam int data_width = 32;
    localparam int max_length = 32;
    localparam int n_jobs     = 16;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  start;
    len_t                  length;
    logic                  in_valid;
    logic [data_width-1:0] in_data;
    logic                  in_ready;
    logic                  out_valid;
    logic [data_width-1:0] out_data;
    logic                  out_last;
    logic                  done;

    logic [31:0]           rng_state = 32'd99;
    int                    fixed_len [8] = '{1, 7, 9, max_length, 8, 16, 3, 25};
    int                    job_len   [n_jobs];
    logic [data_width-1:0] in_words  [max_length];
    logic [data_width-1:0] exp_words [max_length];
    int                    cur_len;
    int                    out_count;
    int                    done_count;
    int                    cycle_count;
    int                    cycle_limit;
    int                    word_errors;
    int                    last_errors;
    int                    other_errors;
    logic                  last_seen;

    merge_sort_top #(
        .DATA_WIDTH(data_width),
        .MAX_LENGTH(max_length)
    ) u_merge_sort_top (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .length    (length),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .done      (done)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_word(input logic [data_width-1:0] actual, input len_t index);
        if (actual !== exp_words[index]) begin
            $display("error at %0t ns: out_data[%0d] expected %h got %h",
                     $time, index, exp_words[index], actual);
            word_errors++;
        end
    endtask

    task automatic check_last(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error at %0t ns: out_last expected %b got %b", $time, expected, actual);
            last_errors++;
        end
    endtask

    // Job modes cycle through random, few distinct values, all equal and
    // a mix that includes the all-ones word the sorter uses for padding
    task automatic make_words(input int j, input int n);
        logic [data_width-1:0] fixed_value;
        fixed_value = xorshift();
        for (int i = 0; i < n; i++) begin
            case (j % 4)
                0: in_words[i] = xorshift();
                1: in_words[i] = xorshift() % 5;
                2: in_words[i] = fixed_value;
                default: in_words[i] = (xorshift() % 2 == 0) ? '1 : xorshift() % 16;
            endcase
        end
    endtask

    // Reference model is a plain insertion sort on a copy of the input
    task automatic sort_model(input int n);
        logic [data_width-1:0] key;
        int                    k;
        for (int i = 0; i < n; i++) begin
            exp_words[i] = in_words[i];
        end
        for (int i = 1; i < n; i++) begin
            key = exp_words[i];
            k = i - 1;
            while (k >= 0 && exp_words[k] > key) begin
                exp_words[k+1] = exp_words[k];
                k--;
            end
            exp_words[k+1] = key;
        end
    endtask

    // The job state moves one cycle after start, so in_ready shows it at the next fall
    task automatic bad_start(input len_t bad_length);
        start = 1'b1;
        length = bad_length;
        @(negedge clock);
        start = 1'b0;
        if (in_ready) begin
            $display("in_ready went high at %0t ns after a start with invalid length %0d",
                     $time, bad_length);
            other_errors++;
        end
    endtask

    task automatic run_job(input int j);
        int   n;
        int   idx;
        logic sent;
        logic poked;
        n = job_len[j];
        make_words(j, n);
        sort_model(n);
        cur_len = n;
        out_count = 0;
        start = 1'b1;
        length = len_t'(n);
        @(negedge clock);
        start = 1'b0;
        idx = 0;
        poked = 1'b0;
        while (idx < n) begin
            in_valid = (xorshift() % 4) != 0;
            in_data = in_valid ? in_words[idx] : xorshift();
            // Odd jobs see a stray start halfway through loading
            if ((j % 2 == 1) && !poked && (idx == n / 2)) begin
                start = 1'b1;
                length = len_t'(xorshift() % max_length + 1);
                poked = 1'b1;
            end
            sent = in_valid && in_ready;
            @(negedge clock);
            start = 1'b0;
            if (sent) begin
                idx++;
            end
        end
        in_valid = 1'b0;
        wait (done_count == j + 1);
        @(negedge clock);
        if (out_count != n) begin
            $display("job %0d produced %0d output words instead of %0d", j, out_count, n);
            other_errors++;
        end
    endtask

    // The output monitor samples mid-cycle while the DUT outputs are stable
    always @(negedge clock) begin
        if (!reset) begin
            if (last_seen && !done) begin
                $display("done did not pulse at %0t ns, one cycle after out_last", $time);
                other_errors++;
            end
            if (done && !last_seen) begin
                $display("done pulsed at %0t ns without out_last the cycle before", $time);
                other_errors++;
            end
            if (done) begin
                done_count++;
            end
            if (out_valid) begin
                if (out_count >= cur_len) begin
                    $display("extra output word %h at %0t ns beyond the job length %0d",
                             out_data, $time, cur_len);
                    other_errors++;
                end else begin
                    check_word(out_data, len_t'(out_count));
                    check_last(out_last, out_count == cur_len - 1);
                end
                out_count++;
            end
            last_seen = out_valid && out_last;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int total_words;
        int assert_errors;
        reset = 1'b1;
        start = 1'b0;
        length = '0;
        in_valid = 1'b0;
        in_data = '0;
        cur_len = 0;
        out_count = 0;
        done_count = 0;
        cycle_count = 0;
        word_errors = 0;
        last_errors = 0;
        other_errors = 0;
        last_seen = 1'b0;
        total_words = 0;
        for (int j = 0; j < n_jobs; j++) begin
            job_len[j] = (j < 8) ? fixed_len[j] : int'(xorshift() % max_length + 1);
            total_words += job_len[j];
        end
        cycle_limit = 20 * total_words + 200 * n_jobs;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        for (int j = 0; j < n_jobs; j++) begin
            if (j % 4 == 2) begin
                bad_start((j % 8 == 2) ? len_t'(0) : len_t'(max_length + 1));
            end
            run_job(j);
        end
        assert_errors = u_merge_sort_top.u_props.failures;
        $display("word errors %0d, last errors %0d, other errors %0d, assertion errors %0d",
                 word_errors, last_errors, other_errors, assert_errors);
        if (word_errors + last_errors + other_errors + assert_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verif/merge_sort_props.sv */
`timescale 1ns/1ns

module merge_sort_props import sort_ctrl_pkg::*; (
    input logic         clock,
    input logic         reset,
    input logic         in_ready,
    input logic         out_valid,
    input logic         out_last,
    input logic         done,
    input merge_state_t merge_state,
    input job_state_t   job_state
);

    int failures = 0;

    // The finish state comes right after the final word streams out
    last_then_done: assert property (@(posedge clock) disable iff (reset)
        out_last |=> done)
        else begin
            $error("done did not follow out_last by one cycle");
            failures++;
        end

    done_after_last: assert property (@(posedge clock) disable iff (reset)
        done |-> $past(out_last))
        else begin
            $error("done rose without out_last in the previous cycle");
            failures++;
        end

    // Input words are only taken while the merge unit is still collecting runs
    ready_in_collect: assert property (@(posedge clock) disable iff (reset)
        in_ready |-> (merge_state == st_collect))
        else begin
            $error("in_ready high while the merge unit is not collecting");
            failures++;
        end

    // Output words stream only after the whole job has been taken in
    valid_in_drain: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> (job_state == job_drain))
        else begin
            $error("out_valid high while the job is not draining");
            failures++;
        end

endmodule

bind merge_sort_top merge_sort_props u_props (
    .clock       (clock),
    .reset       (reset),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_last    (out_last),
    .done        (done),
    .merge_state (u_merge.state),
    .job_state   (job_state)
);

/* hw/merge_sort_top.sv */
`timescale 1ns/1ns

module merge_sort_top import sort_geom_pkg::*, sort_ctrl_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_LENGTH = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  len_t                  length,
    input  logic                  in_valid,
    input  logic [DATA_WIDTH-1:0] in_data,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_last,
    output logic                  done
);

    job_state_t            job_state;
    len_t                  n_full_chunks;
    chunk_idx_t            last_size;
    logic                  job_words_done;
    logic                  finish;
    logic                  accept;
    logic                  chunk_end;
    chunk_idx_t            chunk_fill;
    logic                  sorter_idle;
    logic                  run_valid;
    logic [DATA_WIDTH-1:0] run_data;
    logic                  run_end;

    assign done = finish;

    sort_job_regs #(
        .MAX_LENGTH(MAX_LENGTH)
    ) u_job_regs (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .length         (length),
        .job_words_done (job_words_done),
        .finish         (finish),
        .job_state      (job_state),
        .n_full_chunks  (n_full_chunks),
        .last_size      (last_size)
    );

    chunk_framer u_framer (
        .clock          (clock),
        .reset          (reset),
        .job_state      (job_state),
        .n_full_chunks  (n_full_chunks),
        .last_size      (last_size),
        .in_valid       (in_valid),
        .sorter_idle    (sorter_idle),
        .in_ready       (in_ready),
        .accept         (accept),
        .chunk_end      (chunk_end),
        .chunk_fill     (chunk_fill),
        .job_words_done (job_words_done)
    );

    chunk_sorter #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_sorter (
        .clock       (clock),
        .reset       (reset),
        .accept      (accept),
        .in_data     (in_data),
        .chunk_end   (chunk_end),
        .chunk_fill  (chunk_fill),
        .sorter_idle (sorter_idle),
        .run_valid   (run_valid),
        .run_data    (run_data),
        .run_end     (run_end)
    );

    merge_unit #(
        .DATA_WIDTH(DATA_WIDTH),
        .MAX_LENGTH(MAX_LENGTH)
    ) u_merge (
        .clock         (clock),
        .reset         (reset),
        .job_state     (job_state),
        .n_full_chunks (n_full_chunks),
        .last_size     (last_size),
        .run_valid     (run_valid),
        .run_data      (run_data),
        .run_end       (run_end),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_last      (out_last),
        .finish        (finish)
    );

endmodule

/* hw/merge_unit.sv */
`timescale 1ns/1ns

module merge_unit import sort_geom_pkg::*, sort_ctrl_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int MAX_LENGTH = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  job_state_t            job_state,
    input  len_t                  n_full_chunks,
    input  chunk_idx_t            last_size,
    input  logic                  run_valid,
    input  logic [DATA_WIDTH-1:0] run_data,
    input  logic                  run_end,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_last,
    output logic                  finish
);

    localparam int addr_width = $clog2(MAX_LENGTH);

    merge_state_t          state;
    logic [DATA_WIDTH-1:0] bank_a [MAX_LENGTH];
    logic [DATA_WIDTH-1:0] bank_b [MAX_LENGTH];
    logic                  src_is_b;
    len_t                  total_len;
    len_t                  run_width;
    len_t                  base;
    len_t                  i_ptr;
    len_t                  j_ptr;
    len_t                  w_ptr;
    len_t                  left_end;
    len_t                  right_end;
    logic [DATA_WIDTH-1:0] left_word;
    logic [DATA_WIDTH-1:0] right_word;
    logic [DATA_WIDTH-1:0] merged_word;
    logic                  take_left;
    logic                  pair_done;
    logic                  pass_done;
    logic                  store_word;

    assign total_len = len_t'(n_full_chunks * chunk_size) + len_t'(last_size);

    // Both runs of the current pair are clamped to the job length
    assign left_end  = (base + run_width < total_len) ? base + run_width : total_len;
    assign right_end = (base + (run_width << 1) < total_len) ? base + (run_width << 1)
                                                              : total_len;

    assign left_word  = src_is_b ? bank_b[i_ptr[addr_width-1:0]]
                                 : bank_a[i_ptr[addr_width-1:0]];
    assign right_word = src_is_b ? bank_b[j_ptr[addr_width-1:0]]
                                 : bank_a[j_ptr[addr_width-1:0]];

    // Ties go to the left run, keeping the merge stable
    assign take_left   = (i_ptr < left_end) &&
                         ((j_ptr >= right_end) || (left_word <= right_word));
    assign merged_word = take_left ? left_word : right_word;
    assign pair_done   = (w_ptr == right_end - len_t'(1));
    assign pass_done   = pair_done && (right_end == total_len);

    assign store_word = (state == st_collect) && (job_state != job_idle) && run_valid;

    // Emit reuses the left read port to stream the final run
    assign out_valid = (state == st_emit);
    assign out_data  = left_word;
    assign out_last  = out_valid && (i_ptr == total_len - len_t'(1));
    assign finish    = (state == st_finish);

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= st_collect;
            src_is_b  <= 1'b0;
            run_width <= '0;
            base      <= '0;
            i_ptr     <= '0;
            j_ptr     <= '0;
            w_ptr     <= '0;
        end else begin
            case (state)
                st_collect: begin
                    if (job_state == job_idle) begin
                        w_ptr    <= '0;
                        src_is_b <= 1'b0;
                    end else if (run_valid) begin
                        w_ptr <= w_ptr + len_t'(1);
                        if (run_end && (w_ptr == total_len - len_t'(1))) begin
                            i_ptr <= '0;
                            // A single chunk is already one sorted run
                            if (total_len <= len_t'(chunk_size)) begin
                                state <= st_emit;
                            end else begin
                                state     <= st_merge;
                                run_width <= len_t'(chunk_size);
                                base      <= '0;
                                j_ptr     <= len_t'(chunk_size);
                                w_ptr     <= '0;
                            end
                        end
                    end
                end
                st_merge: begin
                    w_ptr <= w_ptr + len_t'(1);
                    if (take_left) begin
                        i_ptr <= i_ptr + len_t'(1);
                    end else begin
                        j_ptr <= j_ptr + len_t'(1);
                    end
                    if (pass_done) begin
                        // The bank just written becomes the source
                        src_is_b  <= !src_is_b;
                        run_width <= run_width << 1;
                        base      <= '0;
                        w_ptr     <= '0;
                        i_ptr     <= '0;
                        j_ptr     <= run_width << 1;
                        if ((run_width << 1) >= total_len) begin
                            state <= st_emit;
                        end
                    end else if (pair_done) begin
                        base  <= base + (run_width << 1);
                        i_ptr <= base + (run_width << 1);
                        j_ptr <= base + (run_width << 1) + run_width;
                    end
                end
                st_emit: begin
                    i_ptr <= i_ptr + len_t'(1);
                    if (out_last) begin
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    state    <= st_collect;
                    w_ptr    <= '0;
                    src_is_b <= 1'b0;
                end
                default: state <= st_collect;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (store_word) begin
            bank_a[w_ptr[addr_width-1:0]] <= run_data;
        end else if (state == st_merge) begin
            if (src_is_b) begin
                bank_a[w_ptr[addr_width-1:0]] <= merged_word;
            end else begin
                bank_b[w_ptr[addr_width-1:0]] <= merged_word;
            end
        end
    end

endmodule

/* hw/chunk_sorter.sv */
`timescale 1ns/1ns

module chunk_sorter import sort_geom_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  accept,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  chunk_end,
    input  chunk_idx_t            chunk_fill,
    output logic                  sorter_idle,
    output logic                  run_valid,
    output logic [DATA_WIDTH-1:0] run_data,
    output logic                  run_end
);

    typedef enum logic [1:0] {
        sorter_load,
        sorter_stage,
        sorter_unload
    } sorter_state_t;

    sorter_state_t         state;
    logic [DATA_WIDTH-1:0] slot      [chunk_size];
    logic [DATA_WIDTH-1:0] stage_out [chunk_size];
    chunk_idx_t            load_idx;
    chunk_idx_t            stage;
    chunk_idx_t            unload_idx;
    chunk_idx_t            fill;

    // One compare-exchange stage of the odd-even transposition network
    // Even stages pair (0,1),(2,3)..., odd stages pair (1,2),(3,4)...
    always_comb begin
        stage_out = slot;
        for (int k = 0; k < chunk_size - 1; k++) begin
            if ((k % 2) == int'(stage[0])) begin
                if (slot[k] > slot[k+1]) begin
                    stage_out[k]   = slot[k+1];
                    stage_out[k+1] = slot[k];
                end
            end
        end
    end

    assign run_valid = (state == sorter_unload);
    assign run_data  = slot[unload_idx];
    assign run_end   = run_valid && (unload_idx == fill);

    // The next chunk may start loading while the last word goes out
    assign sorter_idle = (state == sorter_load) || run_end;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= sorter_load;
            load_idx   <= '0;
            stage      <= '0;
            unload_idx <= '0;
        end else begin
            case (state)
                sorter_stage: begin
                    stage <= stage + chunk_idx_t'(1);
                    if (stage == chunk_idx_t'(chunk_size - 1)) begin
                        state      <= sorter_unload;
                        unload_idx <= '0;
                    end
                end
                sorter_unload: begin
                    unload_idx <= unload_idx + chunk_idx_t'(1);
                    if (run_end) begin
                        state <= sorter_load;
                    end
                end
                default: ;
            endcase
            if (accept) begin
                load_idx <= load_idx + chunk_idx_t'(1);
            end
            if (chunk_end) begin
                state    <= sorter_stage;
                stage    <= '0;
                load_idx <= '0;
            end
        end
    end

    // Unused slots get the largest value so padding sorts past the fill
    always_ff @(posedge clock) begin
        if (state == sorter_stage) begin
            slot <= stage_out;
        end else begin
            if (accept) begin
                slot[load_idx] <= in_data;
            end
            if (chunk_end) begin
                fill <= chunk_fill;
                for (int k = 0; k < chunk_size; k++) begin
                    if (k > int'(chunk_fill)) begin
                        slot[k] <= '1;
                    end
                end
            end
        end
    end

endmodule

/* hw/chunk_framer.sv */
`timescale 1ns/1ns

module chunk_framer import sort_geom_pkg::*, sort_ctrl_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  job_state_t job_state,
    input  len_t       n_full_chunks,
    input  chunk_idx_t last_size,
    input  logic       in_valid,
    input  logic       sorter_idle,
    output logic       in_ready,
    output logic       accept,
    output logic       chunk_end,
    output chunk_idx_t chunk_fill,
    output logic       job_words_done
);

    chunk_idx_t word_count;
    len_t       chunk_count;
    logic       has_tail;
    logic       in_last_chunk;
    chunk_idx_t chunk_limit;

    assign in_ready = (job_state == job_load) && sorter_idle;
    assign accept   = in_valid && in_ready;

    // Without a remainder the final chunk is the last full one
    assign has_tail      = (last_size != '0);
    assign in_last_chunk = has_tail ? (chunk_count == n_full_chunks)
                                    : (chunk_count == n_full_chunks - len_t'(1));
    assign chunk_limit   = (in_last_chunk && has_tail) ? last_size - chunk_idx_t'(1)
                                                       : chunk_idx_t'(chunk_size - 1);

    assign chunk_end      = accept && (word_count == chunk_limit);
    assign job_words_done = chunk_end && in_last_chunk;

    // At chunk_end the word counter holds the fill count minus one
    assign chunk_fill = word_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            word_count  <= '0;
            chunk_count <= '0;
        end else if (job_state == job_idle) begin
            word_count  <= '0;
            chunk_count <= '0;
        end else if (accept) begin
            if (chunk_end) begin
                word_count  <= '0;
                chunk_count <= chunk_count + len_t'(1);
            end else begin
                word_count <= word_count + chunk_idx_t'(1);
            end
        end
    end

endmodule

/* hw/sort_job_regs.sv */
`timescale 1ns/1ns

module sort_job_regs import sort_geom_pkg::*, sort_ctrl_pkg::*; #(
    parameter int MAX_LENGTH = 32
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  len_t       length,
    input  logic       job_words_done,
    input  logic       finish,
    output job_state_t job_state,
    output len_t       n_full_chunks,
    output chunk_idx_t last_size
);

    logic busy;
    logic length_ok;
    logic take_job;

    assign busy      = (job_state != job_idle);
    assign length_ok = (length != '0) && (length <= len_t'(MAX_LENGTH));
    assign take_job  = start && !busy && length_ok;

    always_ff @(posedge clock) begin
        if (reset) begin
            job_state <= job_idle;
        end else begin
            case (job_state)
                job_idle: begin
                    if (take_job) begin
                        job_state <= job_load;
                    end
                end
                job_load: begin
                    // The framer flags the final accepted word of the job
                    if (job_words_done) begin
                        job_state <= job_drain;
                    end
                end
                job_drain: begin
                    if (finish) begin
                        job_state <= job_idle;
                    end
                end
                default: job_state <= job_idle;
            endcase
        end
    end

    // Split the length into whole chunks and a remainder
    always_ff @(posedge clock) begin
        if (take_job) begin
            n_full_chunks <= len_t'(length / chunk_size);
            last_size     <= chunk_idx_t'(length % chunk_size);
        end
    end

endmodule

/* hw/sort_ctrl_pkg.sv */
package sort_ctrl_pkg;

    // Job controller states
    // Load accepts input words, drain waits for the merge unit to finish
    typedef enum logic [1:0] {
        job_idle,
        job_load,
        job_drain
    } job_state_t;

    // Merge engine states
    typedef enum logic [1:0] {
        st_collect,
        st_merge,
        st_emit,
        st_finish
    } merge_state_t;

endpackage

/* hw/sort_geom_pkg.sv */
package sort_geom_pkg;

    // Words in a full chunk; the chunk sorter network is built for this size
    localparam int chunk_size = 8;

    // Position of a word inside a chunk, also used for the size of the
    // partial last chunk (zero when the length is a multiple of the chunk)
    typedef logic [2:0] chunk_idx_t;

    // Job length, word positions and chunk counts all fit this width
    typedef logic [15:0] len_t;

endpackage
